// ==== tb.f ====
+incdir+include
verilog/aznable_pkg.sv
verilog/bus_control.sv
verilog/input_ports.sv
verilog/ms_timer.sv
verilog/system_flags.sv
verilog/work_ram.sv
verilog/io_system.sv
tb/io_system_tb.sv

// ==== tb/io_system_tb.sv ====
`include "aznable_consts.svh"

module io_system_tb;

	typedef enum logic [2:0] {
		step_access,
		step_menu,
		step_pause,
		step_wait,
		step_stall,
		step_menu_level
	} step_kind_t;

	typedef struct packed {
		step_kind_t kind;
		logic write;
		logic [15:0] addr;
		logic [7:0] wdata;
		logic [7:0] expected;
		logic loose;
		logic [31:0] count;
	} step_t;

	localparam int MAX_STEPS = 64;
	localparam int TIMER_WAIT = 2 * `MS_DIVIDE + 500;

	logic clk_24;
	logic reset;
	logic req;
	aznable_pkg::bus_req_t req_data;
	logic ack;
	logic [7:0] rdata;
	aznable_pkg::hw_inputs_t inputs;
	logic pause;
	logic pause_system;

	step_t steps [0:MAX_STEPS-1];
	string step_names [0:MAX_STEPS-1];
	int n_steps = 0;
	int cycle_count = 0;
	int timeout_limit = 32'h7fffffff;
	logic test_failed;

	io_system io_system_inst (
		.clk_24(clk_24),
		.reset(reset),
		.req(req),
		.req_data(req_data),
		.ack(ack),
		.rdata(rdata),
		.inputs(inputs),
		.pause(pause),
		.pause_system(pause_system)
	);

	always
	begin
		#4 clk_24 = ~clk_24;
	end

	always @(posedge clk_24)
	begin
		cycle_count++;
		if (cycle_count > timeout_limit)
		begin
			$display("Timeout after %0d cycles, the bus stopped responding", cycle_count);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	task automatic add_step(input string name, input step_kind_t kind, input logic write,
		input logic [15:0] addr, input logic [7:0] wdata, input logic [7:0] expected,
		input logic loose, input int count);
		steps[n_steps] = {kind, write, addr, wdata, expected, loose, 32'(count)};
		step_names[n_steps] = name;
		n_steps++;
	endtask

	// Byte k of a field, zero past its top bit
	function automatic logic [7:0] field_byte(input logic [255:0] field, input int k);
		return field[k*8 +: 8];
	endfunction

	// Four-phase master, optionally pulsing pause while the request is held off
	task automatic run_access(input string name, input step_t step, output logic [7:0] data);
		int edge_count;
		int accept_edge;
		logic was_paused;
		edge_count = 0;
		accept_edge = 0;
		if (step.kind == step_stall)
		begin
			assert (pause_system) else
			begin
				$display("%s: the system was not paused before the request", name);
				test_failed = 1;
			end
		end
		req_data.addr = step.addr;
		req_data.wdata = step.wdata;
		req_data.write = step.write;
		req = 1'b1;
		while (!ack)
		begin
			@(negedge clk_24);
			was_paused = pause_system;
			@(posedge clk_24);
			#1;
			edge_count++;
			if (accept_edge == 0 && !was_paused)
				accept_edge = edge_count;
			if (pause)
				pause = 1'b0;
			else if (step.kind == step_stall && edge_count == step.count)
				pause = 1'b1;
		end
		assert (edge_count - accept_edge == `ACCESS_LATENCY) else
		begin
			$display("ERROR %s: ack latency expected %0d, actual %0d", name,
				`ACCESS_LATENCY, edge_count - accept_edge);
			test_failed = 1;
		end
		if (step.kind == step_stall)
		begin
			assert (accept_edge > step.count) else
			begin
				$display("%s: the request was served while the system was paused", name);
				test_failed = 1;
			end
		end
		data = rdata;
		// Back-pressure, ack and data hold while req stays high
		repeat (2)
		begin
			@(posedge clk_24);
			#1;
			assert (ack && rdata == data) else
			begin
				$display("%s: ack or read data changed while req was held", name);
				test_failed = 1;
			end
		end
		req = 1'b0;
		@(posedge clk_24);
		#1;
		assert (ack) else
		begin
			$display("%s: ack fell on the edge that sampled req low", name);
			test_failed = 1;
		end
		@(posedge clk_24);
		#1;
		assert (!ack) else
		begin
			$display("%s: ack did not fall one cycle after req was sampled low", name);
			test_failed = 1;
		end
	endtask

	initial
	begin
		logic [383:0] raw;
		logic [31:0] word;
		logic [7:0] ram_data [0:4];
		logic [15:0] ram_addr [0:4];
		logic [7:0] got;
		step_t step;
		int total;
		int passed;
		int failed;

		clk_24 = 1'b0;
		reset = 1'b1;
		req = 1'b0;
		req_data = '0;
		pause = 1'b0;
		inputs = '0;
		passed = 0;
		failed = 0;

		word = $urandom(32'h5b1b);
		for (int i = 0; i < 12; i++)
		begin
			word = $urandom();
			raw[i*32 +: 32] = word;
		end
		inputs = raw[380:0];
		inputs.menu = 1'b0;
		ram_addr[0] = 16'hC000;
		ram_addr[1] = 16'hC001;
		ram_addr[2] = 16'hD5A3;
		ram_addr[3] = 16'hE000;
		ram_addr[4] = 16'hFFFF;
		for (int i = 0; i < 5; i++)
		begin
			word = $urandom();
			ram_data[i] = word[7:0];
		end

		// Status and input readback
		add_step("status byte", step_access, 1'b0, `MAP_IN0, 8'h00, 8'h08, 1'b0, 0);
		add_step("timestamp byte 0", step_access, 1'b0, `MAP_TIMESTAMP, 8'h00,
			field_byte(inputs.timestamp, 0), 1'b0, 0);
		add_step("timestamp byte 4", step_access, 1'b0, `MAP_TIMESTAMP + 16'd4, 8'h00,
			field_byte(inputs.timestamp, 4), 1'b0, 0);
		add_step("joystick byte 0", step_access, 1'b0, `MAP_JOYSTICK, 8'h00,
			field_byte(inputs.joystick, 0), 1'b0, 0);
		add_step("joystick byte 23", step_access, 1'b0, `MAP_JOYSTICK + 16'd23, 8'h00,
			field_byte(inputs.joystick, 23), 1'b0, 0);
		add_step("analog_l byte 5", step_access, 1'b0, `MAP_ANALOG_L + 16'd5, 8'h00,
			field_byte(inputs.analog_l, 5), 1'b0, 0);
		add_step("analog_l byte 11", step_access, 1'b0, `MAP_ANALOG_L + 16'd11, 8'h00,
			field_byte(inputs.analog_l, 11), 1'b0, 0);
		add_step("paddle byte 2", step_access, 1'b0, `MAP_PADDLE + 16'd2, 8'h00,
			field_byte(inputs.paddle, 2), 1'b0, 0);
		add_step("paddle byte 5", step_access, 1'b0, `MAP_PADDLE + 16'd5, 8'h00,
			field_byte(inputs.paddle, 5), 1'b0, 0);
		add_step("ps2_key byte 0", step_access, 1'b0, `MAP_PS2_KEY, 8'h00,
			field_byte(inputs.ps2_key, 0), 1'b0, 0);
		add_step("ps2_key byte 1", step_access, 1'b0, `MAP_PS2_KEY + 16'd1, 8'h00,
			field_byte(inputs.ps2_key, 1), 1'b0, 0);
		add_step("unmapped read", step_access, 1'b0, 16'h4000, 8'h00, 8'h00, 1'b0, 0);
		add_step("gap read", step_access, 1'b0, 16'h8260, 8'h00, 8'h00, 1'b0, 0);
		add_step("pause register read", step_access, 1'b0, `MAP_PAUSE, 8'h00, 8'h00, 1'b0, 0);

		// Work RAM
		for (int i = 0; i < 5; i++)
			add_step($sformatf("ram write %h", ram_addr[i]), step_access, 1'b1, ram_addr[i],
				ram_data[i], 8'h00, 1'b0, 0);
		for (int i = 0; i < 5; i++)
			add_step($sformatf("ram read %h", ram_addr[i]), step_access, 1'b0, ram_addr[i],
				8'h00, ram_data[i], 1'b0, 0);

		// Menu trigger
		add_step("menu idle read", step_access, 1'b0, `MAP_MENU, 8'h00, 8'h00, 1'b0, 0);
		add_step("menu pulse", step_menu, 1'b0, 16'h0000, 8'h00, 8'h00, 1'b0, 0);
		add_step("menu set read", step_access, 1'b0, `MAP_MENU, 8'h00, 8'hFF, 1'b0, 0);
		// Status bit 1 follows the raw menu input
		add_step("menu input high", step_menu_level, 1'b0, 16'h0000, 8'h01, 8'h00, 1'b0, 0);
		add_step("status byte with menu", step_access, 1'b0, `MAP_IN0, 8'h00, 8'h0A, 1'b0, 0);
		add_step("menu input low", step_menu_level, 1'b0, 16'h0000, 8'h00, 8'h00, 1'b0, 0);
		add_step("menu clear", step_access, 1'b1, `MAP_MENU, 8'h00, 8'h00, 1'b0, 0);
		add_step("menu cleared read", step_access, 1'b0, `MAP_MENU, 8'h00, 8'h00, 1'b0, 0);

		// Millisecond timer
		add_step("timer clear", step_access, 1'b1, `MAP_TIMER, 8'h00, 8'h00, 1'b0, 0);
		add_step("timer wait", step_wait, 1'b0, 16'h0000, 8'h00, 8'h00, 1'b0, TIMER_WAIT);
		add_step("timer low byte", step_access, 1'b0, `MAP_TIMER, 8'h00,
			8'(TIMER_WAIT / `MS_DIVIDE), 1'b1, 0);
		add_step("timer high byte", step_access, 1'b0, `MAP_TIMER + 16'd1, 8'h00, 8'h00, 1'b0, 0);

		// Pause trigger
		add_step("pause set", step_access, 1'b1, `MAP_PAUSE, 8'h00, 8'h00, 1'b0, 0);
		add_step("read held by pause", step_stall, 1'b0, ram_addr[1], 8'h00, ram_data[1], 1'b0, 6);
		add_step("pause set again", step_access, 1'b1, `MAP_PAUSE, 8'h00, 8'h00, 1'b0, 0);
		add_step("external pause pulse", step_pause, 1'b0, 16'h0000, 8'h00, 8'h00, 1'b0, 0);
		add_step("read after pause", step_access, 1'b0, ram_addr[0], 8'h00, ram_data[0], 1'b0, 0);

		total = 0;
		for (int i = 0; i < n_steps; i++)
		begin
			if (steps[i].kind == step_wait)
				total += steps[i].count;
			else
				total += 20 + ((steps[i].kind == step_stall) ? int'(steps[i].count) : 0);
		end
		timeout_limit = 2 * total;

		repeat (2) @(posedge clk_24);
		#1;
		reset = 1'b0;
		test_failed = 0;
		assert (!ack && rdata == 8'h00 && !pause_system) else
		begin
			$display("reset state: ack, rdata or pause_system not cleared by reset");
			test_failed = 1;
		end
		if (test_failed)
			failed++;
		else
			passed++;
		$display("[%s] reset state", test_failed ? "fail" : "ok");

		for (int i = 0; i < n_steps; i++)
		begin
			test_failed = 0;
			step = steps[i];
			case (step.kind)
				step_access, step_stall:
				begin
					run_access(step_names[i], step, got);
					if (!step.write && step.loose)
					begin
						assert (got == step.expected || got == step.expected - 8'd1) else
						begin
							$display("ERROR %s: expected %02h or %02h, actual %02h", step_names[i],
								step.expected, step.expected - 8'd1, got);
							test_failed = 1;
						end
					end
					else if (!step.write)
					begin
						assert (got == step.expected) else
						begin
							$display("ERROR %s: expected %02h, actual %02h", step_names[i],
								step.expected, got);
							test_failed = 1;
						end
					end
				end
				step_menu:
				begin
					inputs.menu = 1'b1;
					@(posedge clk_24);
					#1;
					inputs.menu = 1'b0;
				end
				step_menu_level:
				begin
					inputs.menu = step.wdata[0];
					@(posedge clk_24);
					#1;
				end
				step_pause:
				begin
					pause = 1'b1;
					@(posedge clk_24);
					#1;
					pause = 1'b0;
					@(negedge clk_24);
					assert (!pause_system) else
					begin
						$display("%s: pause_system stayed high after the pause pulse",
							step_names[i]);
						test_failed = 1;
					end
					@(posedge clk_24);
					#1;
				end
				default:
				begin
					repeat (step.count) @(posedge clk_24);
					#1;
				end
			endcase
			if (test_failed)
				failed++;
			else
				passed++;
			$display("[%s] %s", test_failed ? "fail" : "ok", step_names[i]);
		end

		$display("Tests: %0d, passed: %0d, failed: %0d", passed + failed, passed, failed);
		if (failed == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== verilog/io_system.sv ====
module io_system (
	input logic clk_24,
	input logic reset,
	input logic req,
	input aznable_pkg::bus_req_t req_data,
	output logic ack,
	output logic [7:0] rdata,
	input aznable_pkg::hw_inputs_t inputs,
	input logic pause,
	output logic pause_system
);

	aznable_pkg::bus_cmd_t cmd;
	aznable_pkg::region_t region;
	logic ram_wr;
	logic timer_clr;
	logic pause_set;
	logic menu_clr;
	logic [7:0] input_byte;
	logic [7:0] timer_byte;
	logic [7:0] menu_byte;
	logic [7:0] ram_byte;

	bus_control bus_control_inst (
		.clk_24(clk_24),
		.reset(reset),
		.req(req),
		.req_data(req_data),
		.pause_system(pause_system),
		.ack(ack),
		.rdata(rdata),
		.cmd(cmd),
		.region(region),
		.ram_wr(ram_wr),
		.timer_clr(timer_clr),
		.pause_set(pause_set),
		.menu_clr(menu_clr),
		.input_byte(input_byte),
		.timer_byte(timer_byte),
		.menu_byte(menu_byte),
		.ram_byte(ram_byte)
	);

	input_ports input_ports_inst (
		.clk_24(clk_24),
		.inputs(inputs),
		.region(region),
		.cmd(cmd),
		.input_byte(input_byte)
	);

	ms_timer ms_timer_inst (
		.clk_24(clk_24),
		.reset(reset),
		.timer_clr(timer_clr),
		.cmd(cmd),
		.timer_byte(timer_byte)
	);

	system_flags system_flags_inst (
		.clk_24(clk_24),
		.reset(reset),
		.pause(pause),
		.menu(inputs.menu),
		.pause_set(pause_set),
		.menu_clr(menu_clr),
		.pause_system(pause_system),
		.menu_byte(menu_byte)
	);

	work_ram work_ram_inst (
		.clk_24(clk_24),
		.ram_wr(ram_wr),
		.cmd(cmd),
		.ram_byte(ram_byte)
	);

endmodule

// ==== verilog/work_ram.sv ====
`include "aznable_consts.svh"

module work_ram (
	input logic clk_24,
	input logic ram_wr,
	input aznable_pkg::bus_cmd_t cmd,
	output logic [7:0] ram_byte
);

	logic [7:0] mem [0:(2**`WKRAM_WIDTH)-1];
	logic [`WKRAM_WIDTH-1:0] addr;

	assign addr = cmd.offset[`WKRAM_WIDTH-1:0];

	// Read returns the old contents on a write cycle
	always_ff @(posedge clk_24)
	begin
		if (ram_wr)
		begin
			mem[addr] <= cmd.wdata;
		end
		ram_byte <= mem[addr];
	end

endmodule

// ==== verilog/system_flags.sv ====
module system_flags (
	input logic clk_24,
	input logic reset,
	input logic pause,
	input logic menu,
	input logic pause_set,
	input logic menu_clr,
	output logic pause_system,
	output logic [7:0] menu_byte
);

	logic pause_trigger;
	logic menu_trigger;

	// Software pause holds until the external pause releases it
	always_ff @(posedge clk_24)
	begin
		if (reset || pause)
		begin
			pause_trigger <= 1'b0;
		end
		else if (pause_set)
		begin
			pause_trigger <= 1'b1;
		end
	end

	assign pause_system = pause || pause_trigger;

	// Menu request latches until the host acknowledges it
	always_ff @(posedge clk_24)
	begin
		if (reset || menu_clr)
		begin
			menu_trigger <= 1'b0;
		end
		else if (menu)
		begin
			menu_trigger <= 1'b1;
		end
	end

	always_ff @(posedge clk_24)
	begin
		menu_byte <= {8{menu_trigger}};
	end

endmodule

// ==== verilog/ms_timer.sv ====
`include "aznable_consts.svh"

module ms_timer (
	input logic clk_24,
	input logic reset,
	input logic timer_clr,
	input aznable_pkg::bus_cmd_t cmd,
	output logic [7:0] timer_byte
);

	localparam int PRESCALE_W = $clog2(`MS_DIVIDE);

	logic [PRESCALE_W-1:0] prescale;
	logic [15:0] count;

	always_ff @(posedge clk_24)
	begin
		if (reset || timer_clr)
		begin
			prescale <= '0;
			count <= 16'd0;
		end
		else if (prescale == PRESCALE_W'(`MS_DIVIDE - 1))
		begin
			prescale <= '0;
			count <= count + 16'd1;
		end
		else
		begin
			prescale <= prescale + 1'b1;
		end
	end

	// Little endian, offset 0 is the low byte
	assign timer_byte = cmd.offset[0] ? count[15:8] : count[7:0];

endmodule

// ==== verilog/input_ports.sv ====
module input_ports (
	input logic clk_24,
	input aznable_pkg::hw_inputs_t inputs,
	input aznable_pkg::region_t region,
	input aznable_pkg::bus_cmd_t cmd,
	output logic [7:0] input_byte
);

	logic [7:0] status_byte;
	logic [63:0] timestamp_pad;
	logic [255:0] joystick_pad;
	logic [127:0] analog_l_pad;
	logic [63:0] paddle_pad;
	logic [15:0] ps2_key_pad;

	// Video status bits are gone and read as zero
	assign status_byte = {4'b0000, 2'b10, inputs.menu, 1'b0};

	// Fields padded to a power of two bytes so the low offset bits wrap
	// and bytes past the end read as zero
	assign timestamp_pad = {31'd0, inputs.timestamp};
	assign joystick_pad = {64'd0, inputs.joystick};
	assign analog_l_pad = {32'd0, inputs.analog_l};
	assign paddle_pad = {16'd0, inputs.paddle};
	assign ps2_key_pad = {5'd0, inputs.ps2_key};

	always_ff @(posedge clk_24)
	begin
		case (region)
			aznable_pkg::rgn_in0:
				input_byte <= status_byte;
			aznable_pkg::rgn_timestamp:
				input_byte <= timestamp_pad[{cmd.offset[2:0], 3'd0} +: 8];
			aznable_pkg::rgn_joystick:
				input_byte <= joystick_pad[{cmd.offset[4:0], 3'd0} +: 8];
			aznable_pkg::rgn_analog_l:
				input_byte <= analog_l_pad[{cmd.offset[3:0], 3'd0} +: 8];
			aznable_pkg::rgn_paddle:
				input_byte <= paddle_pad[{cmd.offset[2:0], 3'd0} +: 8];
			aznable_pkg::rgn_ps2_key:
				input_byte <= ps2_key_pad[{cmd.offset[0], 3'd0} +: 8];
			default:
				input_byte <= 8'h00;
		endcase
	end

endmodule

// ==== verilog/bus_control.sv ====
`include "aznable_consts.svh"

module bus_control (
	input logic clk_24,
	input logic reset,
	input logic req,
	input aznable_pkg::bus_req_t req_data,
	input logic pause_system,
	output logic ack,
	output logic [7:0] rdata,
	output aznable_pkg::bus_cmd_t cmd,
	output aznable_pkg::region_t region,
	output logic ram_wr,
	output logic timer_clr,
	output logic pause_set,
	output logic menu_clr,
	input logic [7:0] input_byte,
	input logic [7:0] timer_byte,
	input logic [7:0] menu_byte,
	input logic [7:0] ram_byte
);

	localparam int LAT_W = $clog2(`ACCESS_LATENCY + 1);

	aznable_pkg::bus_state_t state;
	logic [LAT_W-1:0] latency_count;
	logic [15:0] base;
	logic [15:0] offset_full;
	logic accept;
	logic [7:0] read_byte;

	// Address decode, checked from the top of the map down
	always_comb
	begin
		region = aznable_pkg::rgn_none;
		base = 16'h0000;
		if (req_data.addr >= `MAP_WKRAM)
		begin
			region = aznable_pkg::rgn_wkram;
			base = `MAP_WKRAM;
		end
		else if (req_data.addr == `MAP_MENU)
		begin
			region = aznable_pkg::rgn_menu;
			base = `MAP_MENU;
		end
		else if (req_data.addr == `MAP_PAUSE)
		begin
			region = aznable_pkg::rgn_pause;
			base = `MAP_PAUSE;
		end
		else if (req_data.addr >= `MAP_PS2_KEY_END)
		begin
			region = aznable_pkg::rgn_none;
		end
		else if (req_data.addr >= `MAP_PS2_KEY)
		begin
			region = aznable_pkg::rgn_ps2_key;
			base = `MAP_PS2_KEY;
		end
		else if (req_data.addr >= `MAP_PADDLE)
		begin
			region = aznable_pkg::rgn_paddle;
			base = `MAP_PADDLE;
		end
		else if (req_data.addr >= `MAP_ANALOG_L)
		begin
			region = aznable_pkg::rgn_analog_l;
			base = `MAP_ANALOG_L;
		end
		else if (req_data.addr >= `MAP_JOYSTICK)
		begin
			region = aznable_pkg::rgn_joystick;
			base = `MAP_JOYSTICK;
		end
		else if (req_data.addr >= `MAP_TIMER)
		begin
			region = aznable_pkg::rgn_timer;
			base = `MAP_TIMER;
		end
		else if (req_data.addr >= `MAP_TIMESTAMP)
		begin
			region = aznable_pkg::rgn_timestamp;
			base = `MAP_TIMESTAMP;
		end
		else if (req_data.addr == `MAP_IN0)
		begin
			region = aznable_pkg::rgn_in0;
			base = `MAP_IN0;
		end
	end

	assign offset_full = req_data.addr - base;
	assign cmd.offset = offset_full[13:0];
	assign cmd.wdata = req_data.wdata;

	// Read byte by region, write-only and unmapped space give zero
	always_comb
	begin
		case (region)
			aznable_pkg::rgn_in0,
			aznable_pkg::rgn_timestamp,
			aznable_pkg::rgn_joystick,
			aznable_pkg::rgn_analog_l,
			aznable_pkg::rgn_paddle,
			aznable_pkg::rgn_ps2_key:
				read_byte = input_byte;
			aznable_pkg::rgn_timer:
				read_byte = timer_byte;
			aznable_pkg::rgn_menu:
				read_byte = menu_byte;
			aznable_pkg::rgn_wkram:
				read_byte = ram_byte;
			default:
				read_byte = 8'h00;
		endcase
	end

	// No new request while the system is paused
	assign accept = (state == aznable_pkg::st_idle) && req && !pause_system;

	always_ff @(posedge clk_24)
	begin
		if (reset)
		begin
			state <= aznable_pkg::st_idle;
			latency_count <= '0;
			ack <= 1'b0;
			rdata <= 8'h00;
			ram_wr <= 1'b0;
			timer_clr <= 1'b0;
			pause_set <= 1'b0;
			menu_clr <= 1'b0;
		end
		else
		begin
			// Strobes are single cycle
			ram_wr <= 1'b0;
			timer_clr <= 1'b0;
			pause_set <= 1'b0;
			menu_clr <= 1'b0;
			case (state)
				aznable_pkg::st_idle:
				begin
					if (accept)
					begin
						state <= aznable_pkg::st_access;
						latency_count <= '0;
						if (req_data.write)
						begin
							ram_wr <= region == aznable_pkg::rgn_wkram;
							timer_clr <= region == aznable_pkg::rgn_timer;
							pause_set <= region == aznable_pkg::rgn_pause;
							menu_clr <= region == aznable_pkg::rgn_menu;
						end
					end
				end
				aznable_pkg::st_access:
				begin
					// Registered datapath reads have settled by the last count
					if (latency_count == LAT_W'(`ACCESS_LATENCY - 1))
					begin
						ack <= 1'b1;
						rdata <= req_data.write ? 8'h00 : read_byte;
						state <= aznable_pkg::st_ack_wait;
					end
					else
					begin
						latency_count <= latency_count + 1'b1;
					end
				end
				aznable_pkg::st_ack_wait:
				begin
					if (!req)
					begin
						state <= aznable_pkg::st_release;
					end
				end
				aznable_pkg::st_release:
				begin
					ack <= 1'b0;
					state <= aznable_pkg::st_idle;
				end
				default:
				begin
					state <= aznable_pkg::st_idle;
				end
			endcase
		end
	end

endmodule

// ==== verilog/aznable_pkg.sv ====
package aznable_pkg;

	// Request held stable by the bus master while req is high
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0] wdata;
		logic write;
	} bus_req_t;

	// Offset within the addressed region, broadcast to every datapath
	typedef struct packed {
		logic [13:0] offset;
		logic [7:0] wdata;
	} bus_cmd_t;

	typedef enum logic [3:0] {
		rgn_none,
		rgn_in0,
		rgn_timestamp,
		rgn_timer,
		rgn_joystick,
		rgn_analog_l,
		rgn_paddle,
		rgn_ps2_key,
		rgn_pause,
		rgn_menu,
		rgn_wkram
	} region_t;

	typedef enum logic [1:0] {
		st_idle,
		st_access,
		st_ack_wait,
		st_release
	} bus_state_t;

	// Hardware inputs as seen from the host side
	typedef struct packed {
		logic menu;
		logic [32:0] timestamp;
		logic [191:0] joystick;
		logic [95:0] analog_l;
		logic [47:0] paddle;
		logic [10:0] ps2_key;
	} hw_inputs_t;

endpackage

// ==== include/aznable_consts.svh ====
`ifndef AZNABLE_CONSTS_SVH
`define AZNABLE_CONSTS_SVH

// Upper I/O page region bases
// A region runs up to the next base
`define MAP_IN0 16'h8000
`define MAP_TIMESTAMP 16'h8002
`define MAP_TIMER 16'h802A
`define MAP_JOYSTICK 16'h803A
`define MAP_ANALOG_L 16'h80FA
`define MAP_PADDLE 16'h81BA
`define MAP_PS2_KEY 16'h824A

// Nothing is mapped between the PS/2 key block and the pause register
`define MAP_PS2_KEY_END 16'h8256

// Single byte system registers
`define MAP_PAUSE 16'h82B6
`define MAP_MENU 16'h82B7

// Work RAM fills the top 16 KB
`define MAP_WKRAM 16'hC000

// Work RAM address bits
`define WKRAM_WIDTH 14

// clk_24 cycles per millisecond tick
`define MS_DIVIDE 24000

// Cycles from request accept to ack
`define ACCESS_LATENCY 2

`endif
